/* flist.f */
source/vgaPkg.sv
source/dualPortRam.sv
source/vgaTiming.sv
source/pixelFetch.sv
source/vgaTop.sv
test/vga_properties.sv
test/vgaTb.sv

/* Makefile */
SOURCES := $(shell cat flist.f)

all: run

obj_dir/VvgaTb: flist.f $(SOURCES)
	verilator --binary --timing --assert --top-module vgaTb -f flist.f

run: obj_dir/VvgaTb
	obj_dir/VvgaTb > sim.log 2>&1; cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* test/vgaTb.sv */
module vgaTb import vgaPkg::*; ();

	// small raster to keep frames short
	localparam int hVisible = 32;
	localparam int hFront = 2;
	localparam int hSyncLen = 4;
	localparam int hBack = 2;
	localparam int vVisible = 16;
	localparam int vFront = 1;
	localparam int vSyncLen = 2;
	localparam int vBack = 1;

	localparam int hTotal = hVisible + hFront + hSyncLen + hBack;
	localparam int vTotal = vVisible + vFront + vSyncLen + vBack;
	localparam int tileDepth = (hVisible / cellSize) * (vVisible / cellSize) * wordsPerCell;
	localparam int tileAddrWidth = $clog2(tileDepth);
	localparam int palDepth = 8;
	localparam int frameTimeout = 3 * hTotal * vTotal * pixDivide;

	logic CLK;
	logic rst;
	logic tileWrEn;
	logic [tileAddrWidth-1:0] tileWrAddr;
	tileWordT tileWrData;
	logic palWrEn;
	palIndexT palWrAddr;
	rgbT palWrData;
	rgbT rgb;
	logic hSync;
	logic vSync;
	logic de;
	logic pixStrobe;

	// host side copies of both memories
	tileWordT tileMirror [tileDepth];
	rgbT palMirror [palDepth];

	int frameCount = 0;
	int checkFrom = 1 << 30;
	int pixelsChecked = 0;
	int errorCount = 0;

	vgaTop #(
		.hVisible(hVisible),
		.hFront(hFront),
		.hSyncLen(hSyncLen),
		.hBack(hBack),
		.vVisible(vVisible),
		.vFront(vFront),
		.vSyncLen(vSyncLen),
		.vBack(vBack)
	) vgaTop_inst (
		.CLK(CLK),
		.rst(rst),
		.tileWrEn(tileWrEn),
		.tileWrAddr(tileWrAddr),
		.tileWrData(tileWrData),
		.palWrEn(palWrEn),
		.palWrAddr(palWrAddr),
		.palWrData(palWrData),
		.rgb(rgb),
		.hSync(hSync),
		.vSync(vSync),
		.de(de),
		.pixStrobe(pixStrobe)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// --------------------------------------------------
	// reference model and checks
	// --------------------------------------------------

	// colour of visible pixel (x, y) from the mirrors
	function automatic rgbT expectedRgb(input int x, input int y);
		int cellIndex;
		logic [tileAddrWidth-1:0] wordAddr;
		logic [4:0] bitNum;
		tileWordT word;
		palIndexT index;
		cellIndex = (y / 8) * (hVisible / 8) + (x / 8);
		wordAddr = tileAddrWidth'(cellIndex * 4 + (y % 8) / 2);
		word = tileMirror[wordAddr];
		// upper row of the pair first, leftmost pixel at bit 17
		bitNum = 5'(17 - ((y % 2) * 8 + (x % 8)));
		index = {word[bitNum], word[1:0]};
		return palMirror[index];
	endfunction

	task automatic stopWithFailure();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkRgb(input string name, input rgbT got, input rgbT expected);
		if (got !== expected) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, expected);
			errorCount++;
			stopWithFailure();
		end
	endtask

	task automatic checkCount(input string name, input int got, input int expected);
		if (got != expected) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, expected);
			errorCount++;
			stopWithFailure();
		end
	endtask

	task automatic checkLevel(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, expected);
			errorCount++;
			stopWithFailure();
		end
	endtask

	// --------------------------------------------------
	// host writes and waits
	// --------------------------------------------------

	task automatic writeTile(input logic [tileAddrWidth-1:0] addr, input tileWordT data);
		@(posedge CLK);
		#2;
		tileWrEn = 1'b1;
		tileWrAddr = addr;
		tileWrData = data;
		tileMirror[addr] = data;
		@(posedge CLK);
		#2;
		tileWrEn = 1'b0;
	endtask

	task automatic writePalette(input palIndexT addr, input rgbT data);
		@(posedge CLK);
		#2;
		palWrEn = 1'b1;
		palWrAddr = addr;
		palWrData = data;
		palMirror[addr] = data;
		@(posedge CLK);
		#2;
		palWrEn = 1'b0;
	endtask

	// stops at the next negedge that sees a strobe
	task automatic waitStrobe();
		int cycles;
		cycles = 0;
		@(negedge CLK);
		while (!pixStrobe) begin
			@(negedge CLK);
			cycles++;
			if (cycles > 2 * pixDivide) begin
				$display("timeout while waiting for pixStrobe");
				stopWithFailure();
			end
		end
	endtask

	task automatic waitFrames(input int target);
		int cycles;
		cycles = 0;
		while (frameCount < target) begin
			@(posedge CLK);
			cycles++;
			if (cycles > frameTimeout) begin
				$display("timeout while waiting for vSync of frame %0d", target);
				stopWithFailure();
			end
		end
	endtask

	// --------------------------------------------------
	// comparator
	// --------------------------------------------------

	initial begin
		int x;
		int y;
		int hLow;
		int vLow;
		int lineStrobes;
		int frameStrobes;
		bit seenHFall;
		bit seenVFall;
		logic prevDe;
		logic prevHSync;
		logic prevVSync;
		x = 0;
		y = 0;
		hLow = 0;
		vLow = 0;
		lineStrobes = 0;
		frameStrobes = 0;
		seenHFall = 1'b0;
		seenVFall = 1'b0;
		prevDe = 1'b0;
		prevHSync = 1'b1;
		prevVSync = 1'b1;
		forever begin
			@(negedge CLK);
			if (!rst && pixStrobe) begin
				if (!de) begin
					checkRgb("rgb in blanking", rgb, 8'h00);
				end
				// line length and hSync width
				if (prevHSync && !hSync) begin
					if (seenHFall) begin
						checkCount("strobes per line", lineStrobes, hTotal);
					end
					seenHFall = 1'b1;
					lineStrobes = 0;
				end
				lineStrobes++;
				if (!prevHSync && hSync) begin
					checkCount("hSync low strobes", hLow, hSyncLen);
					hLow = 0;
				end
				if (!hSync) begin
					hLow++;
				end
				// frame length, vSync width and visible lines
				if (prevVSync && !vSync) begin
					if (seenVFall) begin
						checkCount("strobes per frame", frameStrobes, hTotal * vTotal);
						checkCount("lines with de", y, vVisible);
					end
					seenVFall = 1'b1;
					frameStrobes = 0;
					frameCount++;
					y = 0;
				end
				frameStrobes++;
				if (!prevVSync && vSync) begin
					checkCount("vSync low strobes", vLow, vSyncLen * hTotal);
					vLow = 0;
				end
				if (!vSync) begin
					vLow++;
				end
				// pixel data
				if (de) begin
					if (frameCount >= checkFrom) begin
						checkRgb($sformatf("rgb(%0d,%0d)", x, y), rgb, expectedRgb(x, y));
						pixelsChecked++;
					end
					x++;
				end else if (prevDe) begin
					checkCount("pixels per line", x, hVisible);
					x = 0;
					y++;
				end
				prevDe = de;
				prevHSync = hSync;
				prevVSync = vSync;
			end
		end
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------

	initial begin
		rst = 1'b1;
		tileWrEn = 1'b0;
		tileWrAddr = '0;
		tileWrData = '0;
		palWrEn = 1'b0;
		palWrAddr = '0;
		palWrData = '0;
		void'($urandom(8));

		repeat (5) @(posedge CLK);
		#2;
		rst = 1'b0;

		// pipeline still empty on the first two strobes
		repeat (2) begin
			waitStrobe();
			checkLevel("de", de, 1'b0);
			checkRgb("rgb", rgb, 8'h00);
			checkLevel("hSync", hSync, 1'b1);
			checkLevel("vSync", vSync, 1'b1);
		end

		for (int i = 0; i < palDepth; i++) begin
			writePalette(palIndexT'(i), rgbT'($urandom));
		end
		for (int i = 0; i < tileDepth; i++) begin
			writeTile(tileAddrWidth'(i), tileWordT'($urandom));
		end

		// first frame that starts after loading is checked in full
		checkFrom = frameCount + 1;
		waitFrames(checkFrom + 1);

		// rewrite during vertical blanking
		for (int i = 0; i < palDepth; i++) begin
			writePalette(palIndexT'(i), rgbT'($urandom));
		end
		for (int i = 0; i < 8; i++) begin
			writeTile(tileAddrWidth'($urandom % tileDepth), tileWordT'($urandom));
		end
		waitFrames(checkFrom + 2);

		checkCount("pixels checked", pixelsChecked, 2 * hVisible * vVisible);

		if (errorCount == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			stopWithFailure();
		end
	end

endmodule

/* test/vga_properties.sv */
module vga_properties import vgaPkg::*; (
	input logic CLK,
	input logic rst,
	input rgbT  rgb,
	input logic hSync,
	input logic vSync,
	input logic de,
	input logic pixStrobe
);

	// --------------------------------------------------
	// output rules
	// --------------------------------------------------

	// blanking is black
	blankIsBlack: assert property (@(posedge CLK) disable iff (rst) !de |-> rgb == 8'h00)
		else $error("rgb is not zero while de is low");

	// one clock wide, one pixel period apart
	strobeSpacing: assert property (@(posedge CLK) disable iff (rst)
		pixStrobe |=> !pixStrobe ##1 !pixStrobe ##1 !pixStrobe ##1 pixStrobe)
		else $error("pixStrobe is not a single pulse every four clocks");

	// reset parks both syncs in their idle level
	syncIdleInReset: assert property (@(posedge CLK) rst |=> hSync && vSync)
		else $error("a sync output is low while reset is applied");

endmodule

bind vgaTop vga_properties vga_properties_inst (
	.CLK(CLK),
	.rst(rst),
	.rgb(rgb),
	.hSync(hSync),
	.vSync(vSync),
	.de(de),
	.pixStrobe(pixStrobe)
);

/* source/vgaTop.sv */
module vgaTop import vgaPkg::*; #(
	parameter int hVisible = defaultHVisible,
	parameter int hFront = defaultHFront,
	parameter int hSyncLen = defaultHSync,
	parameter int hBack = defaultHBack,
	parameter int vVisible = defaultVVisible,
	parameter int vFront = defaultVFront,
	parameter int vSyncLen = defaultVSync,
	parameter int vBack = defaultVBack,
	// sized from the visible raster, not meant to be overridden
	parameter int tileDepth = (hVisible / cellSize) * (vVisible / cellSize) * wordsPerCell,
	parameter int tileAddrWidth = $clog2(tileDepth)
) (
	input  logic                     CLK,
	input  logic                     rst,
	// host writes
	input  logic                     tileWrEn,
	input  logic [tileAddrWidth-1:0] tileWrAddr,
	input  tileWordT                 tileWrData,
	input  logic                     palWrEn,
	input  palIndexT                 palWrAddr,
	input  rgbT                      palWrData,
	// video out
	output rgbT                      rgb,
	output logic                     hSync,
	output logic                     vSync,
	output logic                     de,
	output logic                     pixStrobe
);

	localparam int palDepth = 1 << $bits(palIndexT);

	logic pixEn;
	posT hPos;
	posT vPos;
	logic active;
	logic hSyncRaw;
	logic vSyncRaw;

	logic tileRdEn;
	logic [tileAddrWidth-1:0] tileRdAddr;
	tileWordT tileRdData;

	logic palRdEn;
	palIndexT palRdAddr;
	rgbT palRdData;

	logic fetchActive;
	logic fetchHSync;
	logic fetchVSync;

	// --------------------------------------------------
	// raster timing
	// --------------------------------------------------

	vgaTiming #(
		.hVisible(hVisible),
		.hFront(hFront),
		.hSyncLen(hSyncLen),
		.hBack(hBack),
		.vVisible(vVisible),
		.vFront(vFront),
		.vSyncLen(vSyncLen),
		.vBack(vBack)
	) vgaTiming_inst (
		.CLK(CLK),
		.rst(rst),
		.pixEn(pixEn),
		.hPos(hPos),
		.vPos(vPos),
		.active(active),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw)
	);

	// --------------------------------------------------
	// tile memory and fetch
	// --------------------------------------------------

	dualPortRam #(
		.dataT(tileWordT),
		.depth(tileDepth),
		.addrWidth(tileAddrWidth)
	) tileRam_inst (
		.CLK(CLK),
		.wrEn(tileWrEn),
		.wrAddr(tileWrAddr),
		.wrData(tileWrData),
		.rdEn(tileRdEn),
		.rdAddr(tileRdAddr),
		.rdData(tileRdData)
	);

	pixelFetch #(
		.hVisible(hVisible),
		.tileAddrWidth(tileAddrWidth)
	) pixelFetch_inst (
		.CLK(CLK),
		.rst(rst),
		.pixEn(pixEn),
		.hPos(hPos),
		.vPos(vPos),
		.active(active),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw),
		.tileRdEn(tileRdEn),
		.tileRdAddr(tileRdAddr),
		.tileRdData(tileRdData),
		.palRdEn(palRdEn),
		.palRdAddr(palRdAddr),
		.fetchActive(fetchActive),
		.fetchHSync(fetchHSync),
		.fetchVSync(fetchVSync)
	);

	// --------------------------------------------------
	// palette
	// --------------------------------------------------

	dualPortRam #(
		.dataT(rgbT),
		.depth(palDepth),
		.addrWidth($bits(palIndexT))
	) palRam_inst (
		.CLK(CLK),
		.wrEn(palWrEn),
		.wrAddr(palWrAddr),
		.wrData(palWrData),
		.rdEn(palRdEn),
		.rdAddr(palRdAddr),
		.rdData(palRdData)
	);

	// --------------------------------------------------
	// output register, stage 3
	// --------------------------------------------------

	// black during blanking so the monitor sees a clean porch
	always_ff @(posedge CLK) begin
		if (rst) begin
			rgb <= '0;
			de <= 1'b0;
			hSync <= 1'b1;
			vSync <= 1'b1;
		end else if (pixEn) begin
			rgb <= fetchActive ? palRdData : '0;
			de <= fetchActive;
			hSync <= fetchHSync;
			vSync <= fetchVSync;
		end
	end

	// marks the first cycle of each new output pixel
	always_ff @(posedge CLK) begin
		if (rst) begin
			pixStrobe <= 1'b0;
		end else begin
			pixStrobe <= pixEn;
		end
	end

endmodule

/* source/pixelFetch.sv */
module pixelFetch import vgaPkg::*; #(
	parameter int hVisible = defaultHVisible,
	parameter int tileAddrWidth = 14
) (
	input  logic                     CLK,
	input  logic                     rst,
	input  logic                     pixEn,
	input  posT                      hPos,
	input  posT                      vPos,
	input  logic                     active,
	input  logic                     hSyncRaw,
	input  logic                     vSyncRaw,
	output logic                     tileRdEn,
	output logic [tileAddrWidth-1:0] tileRdAddr,
	input  tileWordT                 tileRdData,
	output logic                     palRdEn,
	output palIndexT                 palRdAddr,
	output logic                     fetchActive,
	output logic                     fetchHSync,
	output logic                     fetchVSync
);

	localparam int cellsPerLine = hVisible / cellSize;
	localparam int posWidth = $bits(posT);

	logic [tileAddrWidth-1:0] cellRow;
	logic [tileAddrWidth-1:0] cellCol;
	logic [tileAddrWidth-1:0] cellIndex;
	logic [tileAddrWidth-1:0] cellBase;

	// stage 1 registers, aligned with the tile RAM output
	logic [3:0] bitPos1;
	logic active1;
	logic hSync1;
	logic vSync1;

	logic [15:0] pixelBits;
	logic pixBit;

	// --------------------------------------------------
	// tile address
	// --------------------------------------------------

	// cell index = row of cells * cells per line + column of cells
	assign cellRow = tileAddrWidth'(vPos[posWidth-1:3]);
	assign cellCol = tileAddrWidth'(hPos[posWidth-1:3]);
	assign cellIndex = cellRow * tileAddrWidth'(cellsPerLine) + cellCol;

	// four words per cell, then the row pair within the cell
	assign cellBase = cellIndex << 2;
	assign tileRdAddr = cellBase | tileAddrWidth'(vPos[2:1]);

	// blanking reads are skipped
	assign tileRdEn = pixEn & active;

	// --------------------------------------------------
	// stage 1
	// --------------------------------------------------

	always_ff @(posedge CLK) begin
		if (pixEn) begin
			// lower row of the pair sits in the low 8 pixel bits
			bitPos1 <= {vPos[0], hPos[2:0]};
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			active1 <= 1'b0;
			hSync1 <= 1'b1;
			vSync1 <= 1'b1;
		end else if (pixEn) begin
			active1 <= active;
			hSync1 <= hSyncRaw;
			vSync1 <= vSyncRaw;
		end
	end

	// --------------------------------------------------
	// palette index
	// --------------------------------------------------

	// leftmost pixel of the upper row is the MSB
	assign pixelBits = tileRdData[17:2];
	assign pixBit = pixelBits[4'd15 - bitPos1];

	assign palRdAddr = {pixBit, tileRdData[1:0]};
	assign palRdEn = pixEn & active1;

	// --------------------------------------------------
	// stage 2
	// --------------------------------------------------

	// these line up with the palette RAM output
	always_ff @(posedge CLK) begin
		if (rst) begin
			fetchActive <= 1'b0;
			fetchHSync <= 1'b1;
			fetchVSync <= 1'b1;
		end else if (pixEn) begin
			fetchActive <= active1;
			fetchHSync <= hSync1;
			fetchVSync <= vSync1;
		end
	end

endmodule

/* source/vgaTiming.sv */
module vgaTiming import vgaPkg::*; #(
	parameter int hVisible = defaultHVisible,
	parameter int hFront = defaultHFront,
	parameter int hSyncLen = defaultHSync,
	parameter int hBack = defaultHBack,
	parameter int vVisible = defaultVVisible,
	parameter int vFront = defaultVFront,
	parameter int vSyncLen = defaultVSync,
	parameter int vBack = defaultVBack
) (
	input  logic CLK,
	input  logic rst,
	output logic pixEn,
	output posT  hPos,
	output posT  vPos,
	output logic active,
	output logic hSyncRaw,
	output logic vSyncRaw
);

	localparam int hTotal = hVisible + hFront + hSyncLen + hBack;
	localparam int vTotal = vVisible + vFront + vSyncLen + vBack;

	// sync windows open after visible plus front porch
	localparam int hSyncStart = hVisible + hFront;
	localparam int hSyncEnd = hSyncStart + hSyncLen;
	localparam int vSyncStart = vVisible + vFront;
	localparam int vSyncEnd = vSyncStart + vSyncLen;

	localparam int divWidth = $clog2(pixDivide);

	logic [divWidth-1:0] divCnt;
	posT hCnt;
	posT vCnt;
	logic lineEnd;
	logic frameEnd;
	logic hInSync;
	logic vInSync;

	// --------------------------------------------------
	// pixel strobe
	// --------------------------------------------------

	// one pulse every pixDivide clocks
	always_ff @(posedge CLK) begin
		if (rst) begin
			divCnt <= '0;
			pixEn <= 1'b0;
		end else if (divCnt == divWidth'(pixDivide - 1)) begin
			divCnt <= '0;
			pixEn <= 1'b1;
		end else begin
			divCnt <= divCnt + 1'b1;
			pixEn <= 1'b0;
		end
	end

	// --------------------------------------------------
	// raster counters
	// --------------------------------------------------

	assign lineEnd = (hCnt == posT'(hTotal - 1));
	assign frameEnd = (vCnt == posT'(vTotal - 1));

	always_ff @(posedge CLK) begin
		if (rst) begin
			hCnt <= '0;
		end else if (pixEn) begin
			if (lineEnd) begin
				hCnt <= '0;
			end else begin
				hCnt <= hCnt + 1'b1;
			end
		end
	end

	// vertical steps once per line
	always_ff @(posedge CLK) begin
		if (rst) begin
			vCnt <= '0;
		end else if (pixEn && lineEnd) begin
			if (frameEnd) begin
				vCnt <= '0;
			end else begin
				vCnt <= vCnt + 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// decode
	// --------------------------------------------------

	always_comb begin
		hInSync = (hCnt >= posT'(hSyncStart)) && (hCnt < posT'(hSyncEnd));
		vInSync = (vCnt >= posT'(vSyncStart)) && (vCnt < posT'(vSyncEnd));
	end

	assign hPos = hCnt;
	assign vPos = vCnt;
	assign active = (hCnt < posT'(hVisible)) && (vCnt < posT'(vVisible));

	// syncs are active low
	assign hSyncRaw = ~hInSync;
	assign vSyncRaw = ~vInSync;

endmodule

/* source/dualPortRam.sv */
module dualPortRam #(
	parameter type dataT = logic [7:0],
	parameter int depth = 256,
	parameter int addrWidth = $clog2(depth)
) (
	input  logic                 CLK,
	input  logic                 wrEn,
	input  logic [addrWidth-1:0] wrAddr,
	input  dataT                 wrData,
	input  logic                 rdEn,
	input  logic [addrWidth-1:0] rdAddr,
	output dataT                 rdData
);

	// storage, no reset on the array
	dataT mem [depth];

	// --------------------------------------------------
	// write port
	// --------------------------------------------------

	always_ff @(posedge CLK) begin
		if (wrEn) begin
			mem[wrAddr] <= wrData;
		end
	end

	// --------------------------------------------------
	// read port
	// --------------------------------------------------

	// registered read, output holds between enabled reads
	// a read of the address being written returns the old word
	always_ff @(posedge CLK) begin
		if (rdEn) begin
			rdData <= mem[rdAddr];
		end
	end

endmodule

/* source/vgaPkg.sv */
package vgaPkg;

	// --------------------------------------------------
	// pixel and memory types
	// --------------------------------------------------

	// displayed colour, RRRGGGBB
	typedef logic [7:0] rgbT;

	// one tile memory word
	// bits 17..2 hold two pixel rows, upper row first, leftmost pixel at the MSB
	// bits 1..0 select the colour pair in the palette
	typedef logic [17:0] tileWordT;

	// palette index, pixel bit followed by the colour selector
	typedef logic [2:0] palIndexT;

	// raster position, wide enough for the full horizontal total
	typedef logic [10:0] posT;

	// --------------------------------------------------
	// raster defaults
	// --------------------------------------------------

	// horizontal, in pixels
	localparam int defaultHVisible = 640;
	localparam int defaultHFront = 16;
	localparam int defaultHSync = 96;
	localparam int defaultHBack = 48;

	// vertical, in lines
	localparam int defaultVVisible = 480;
	localparam int defaultVFront = 10;
	localparam int defaultVSync = 2;
	localparam int defaultVBack = 33;

	// system clocks per pixel
	localparam int pixDivide = 4;

	// cell geometry
	localparam int cellSize = 8;
	localparam int wordsPerCell = 4;

endpackage
